/* Makefile */
# Verilator simulation of the branch predictor testbench

VERILATOR ?= verilator
TOP       ?= bpred_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/bpred_checker.sv */
// Prediction checker: compares the DUT prediction with the expected row and keeps counts
`timescale 1ns/1ps

module bpred_checker
   import bpred_pkg::*;
(
   input  logic     clock,
   input  logic     check_en,
   input  int       row_id,
   input  predict_t prediction,
   input  predict_t expected,
   output int       pass_count,
   output int       fail_count
);

   initial begin
      pass_count = 0;
      fail_count = 0;
   end

   //////////////////////////////////////////////////
   // Compare away from the driving edge
   //////////////////////////////////////////////////

   always @(negedge clock) begin
      if (check_en) begin
         if (prediction === expected) begin
            pass_count <= pass_count + 1;
            $display("row %0d ok: pc=%h next_pc=%h taken=%b", row_id,
                     prediction.pc, prediction.next_pc, prediction.taken);
         end else begin
            fail_count <= fail_count + 1;
            $display("error %0t: row %0d got valid=%b pc=%h next_pc=%h taken=%b",
                     $time, row_id, prediction.valid, prediction.pc,
                     prediction.next_pc, prediction.taken);
            $display("   expected valid=%b pc=%h next_pc=%h taken=%b",
                     expected.valid, expected.pc, expected.next_pc, expected.taken);
         end
      end
   end

endmodule

/* bench/bpred_tb.sv */
// Branch predictor testbench: clock, reset, stimulus table, watchdog and DUT
`timescale 1ns/1ps

module bpred_tb
   import bpred_pkg::*;
;

   typedef struct packed {
      logic            stall;
      logic            redirect_valid;
      logic [XLEN-1:0] redirect_pc;
      resolve_t        res0;
      resolve_t        res1;
      predict_t        expected;
   } row_t;

   localparam resolve_t IDLE = '0;

   logic            clock;
   logic            reset;
   logic            stall;
   logic            redirect_valid;
   logic [XLEN-1:0] redirect_pc;
   resolve_t        resolve [2];
   predict_t        prediction;
   predict_t        expected;
   logic            check_en;
   int              row_id;
   int              pass_count;
   int              fail_count;
   logic            table_ready;
   row_t            rows [$];

   branch_predictor branch_predictor_i (
      .clock          (clock),
      .reset          (reset),
      .stall          (stall),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc),
      .resolve        (resolve),
      .prediction     (prediction)
   );

   bpred_checker checker_i (
      .clock      (clock),
      .check_en   (check_en),
      .row_id     (row_id),
      .prediction (prediction),
      .expected   (expected),
      .pass_count (pass_count),
      .fail_count (fail_count)
   );

   function automatic resolve_t branch(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] target,
                                       input logic taken);
      resolve_t r;
      r.valid  = 1'b1;
      r.pc     = pc;
      r.target = target;
      r.taken  = taken;
      return r;
   endfunction

   task automatic add_row(input logic st, input logic rv, input logic [XLEN-1:0] rpc,
                          input resolve_t r0, input resolve_t r1, input logic ev,
                          input logic [XLEN-1:0] epc, input logic [XLEN-1:0] enext,
                          input logic etaken);
      row_t row;
      row.stall          = st;
      row.redirect_valid = rv;
      row.redirect_pc    = rpc;
      row.res0           = r0;
      row.res1           = r1;
      row.expected       = '{valid: ev, pc: epc, next_pc: enext, taken: etaken};
      rows.push_back(row);
   endtask

   task automatic build_table();
      // Reset, then learn A at 1010 with two taken resolves
      add_row(1'b0, 1'b0, '0, IDLE, IDLE, 1'b0, 32'h1000, 32'h1004, 1'b0);
      add_row(1'b0, 1'b0, '0, branch(32'h1010, 32'h2000, 1'b1), IDLE,
              1'b1, 32'h1004, 32'h1008, 1'b0);
      add_row(1'b0, 1'b0, '0, branch(32'h1010, 32'h2000, 1'b1), IDLE,
              1'b1, 32'h1008, 32'h100c, 1'b0);
      add_row(1'b0, 1'b0, '0, IDLE, IDLE, 1'b1, 32'h100c, 32'h1010, 1'b0);
      add_row(1'b0, 1'b0, '0, IDLE, IDLE, 1'b1, 32'h1010, 32'h2000, 1'b1);
      // Stall holds, redirect loads under stall and beats a taken target
      add_row(1'b1, 1'b0, '0, IDLE, IDLE, 1'b1, 32'h2000, 32'h2004, 1'b0);
      add_row(1'b1, 1'b0, '0, IDLE, IDLE, 1'b1, 32'h2000, 32'h2004, 1'b0);
      add_row(1'b1, 1'b1, 32'h1010, IDLE, IDLE, 1'b1, 32'h2000, 32'h1010, 1'b0);
      add_row(1'b0, 1'b1, 32'h3000, IDLE, IDLE, 1'b1, 32'h1010, 32'h3000, 1'b0);
      add_row(1'b0, 1'b0, '0, IDLE, IDLE, 1'b1, 32'h3000, 32'h3004, 1'b0);
      // B fills way 1 of set 4 and a fetch of A leaves B to be replaced by C
      add_row(1'b0, 1'b0, '0, branch(32'h1050, 32'h4000, 1'b1), IDLE,
              1'b1, 32'h3004, 32'h3008, 1'b0);
      add_row(1'b0, 1'b1, 32'h1010, IDLE, IDLE, 1'b1, 32'h3008, 32'h1010, 1'b0);
      add_row(1'b0, 1'b0, '0, IDLE, IDLE, 1'b1, 32'h1010, 32'h2000, 1'b1);
      add_row(1'b0, 1'b0, '0, branch(32'h1090, 32'h5000, 1'b1), IDLE,
              1'b1, 32'h2000, 32'h2004, 1'b0);
      add_row(1'b0, 1'b1, 32'h1050, IDLE, IDLE, 1'b1, 32'h2004, 32'h1050, 1'b0);
      add_row(1'b0, 1'b0, '0, IDLE, IDLE, 1'b1, 32'h1050, 32'h1054, 1'b0);
      add_row(1'b0, 1'b1, 32'h1090, IDLE, IDLE, 1'b1, 32'h1054, 32'h1090, 1'b0);
      add_row(1'b0, 1'b0, '0, IDLE, IDLE, 1'b1, 32'h1090, 32'h5000, 1'b1);
      add_row(1'b0, 1'b1, 32'h1014, IDLE, IDLE, 1'b1, 32'h5000, 32'h1014, 1'b0);
      // Dual resolve into sets 8 and 12
      add_row(1'b0, 1'b0, '0, branch(32'h1020, 32'h6000, 1'b1), branch(32'h1030, 32'h7000, 1'b1),
              1'b1, 32'h1014, 32'h1018, 1'b0);
      add_row(1'b0, 1'b0, '0, IDLE, IDLE, 1'b1, 32'h1018, 32'h101c, 1'b0);
      add_row(1'b0, 1'b0, '0, IDLE, IDLE, 1'b1, 32'h101c, 32'h1020, 1'b0);
      add_row(1'b0, 1'b0, '0, IDLE, IDLE, 1'b1, 32'h1020, 32'h6000, 1'b1);
      add_row(1'b0, 1'b1, 32'h1030, IDLE, IDLE, 1'b1, 32'h6000, 32'h1030, 1'b0);
      add_row(1'b0, 1'b0, '0, IDLE, IDLE, 1'b1, 32'h1030, 32'h7000, 1'b1);
      // Only F on port 0 is kept when both ports hit set 9
      add_row(1'b0, 1'b0, '0, branch(32'h1124, 32'h8000, 1'b1), branch(32'h1164, 32'h9000, 1'b1),
              1'b1, 32'h7000, 32'h7004, 1'b0);
      add_row(1'b0, 1'b1, 32'h1124, IDLE, IDLE, 1'b1, 32'h7004, 32'h1124, 1'b0);
      add_row(1'b0, 1'b0, '0, IDLE, IDLE, 1'b1, 32'h1124, 32'h8000, 1'b1);
      add_row(1'b0, 1'b1, 32'h1164, IDLE, IDLE, 1'b1, 32'h8000, 32'h1164, 1'b0);
      add_row(1'b0, 1'b0, '0, IDLE, IDLE, 1'b1, 32'h1164, 32'h1168, 1'b0);
      // Not-taken training of F while its BTB entry stays
      add_row(1'b0, 1'b0, '0, branch(32'h1124, 32'h8000, 1'b0), IDLE,
              1'b1, 32'h1168, 32'h116c, 1'b0);
      add_row(1'b0, 1'b0, '0, branch(32'h1124, 32'h8000, 1'b0), IDLE,
              1'b1, 32'h116c, 32'h1170, 1'b0);
      add_row(1'b0, 1'b1, 32'h1124, IDLE, IDLE, 1'b1, 32'h1170, 32'h1124, 1'b0);
      add_row(1'b0, 1'b0, '0, IDLE, IDLE, 1'b1, 32'h1124, 32'h1128, 1'b0);
   endtask

   initial begin
      clock = 1'b0;
      forever #2 clock = ~clock;
   end

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   initial begin
      reset          = 1'b1;
      stall          = 1'b0;
      redirect_valid = 1'b0;
      redirect_pc    = '0;
      resolve[0]     = IDLE;
      resolve[1]     = IDLE;
      expected       = '0;
      check_en       = 1'b0;
      row_id         = 0;
      table_ready    = 1'b0;
      build_table();
      table_ready = 1'b1;
      repeat (2) @(posedge clock);
      reset <= 1'b0;
      for (int r = 0; r < rows.size(); r++) begin
         stall          <= rows[r].stall;
         redirect_valid <= rows[r].redirect_valid;
         redirect_pc    <= rows[r].redirect_pc;
         resolve[0]     <= rows[r].res0;
         resolve[1]     <= rows[r].res1;
         expected       <= rows[r].expected;
         row_id         <= r;
         check_en       <= 1'b1;
         @(posedge clock);
      end
      check_en       <= 1'b0;
      stall          <= 1'b0;
      redirect_valid <= 1'b0;
      resolve[0]     <= IDLE;
      resolve[1]     <= IDLE;
      @(negedge clock);
      $display("rows checked: %0d passed, %0d failed", pass_count, fail_count);
      if (fail_count == 0 && pass_count == rows.size()) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   // Table length plus reset cycles, with some slack
   initial begin
      wait (table_ready);
      #((rows.size() + 2) * 4 + 100);
      $display("simulation timed out before all table rows were applied");
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

/* src.f */
src/bpred_pkg.sv
src/btb.sv
src/bimodal_counters.sv
src/fetch_pc_gen.sv
src/branch_predictor.sv
bench/bpred_checker.sv
bench/bpred_tb.sv

/* src/bimodal_counters.sv */
// Bimodal direction table of two-bit saturating counters with two update ports
`timescale 1ns/1ps

module bimodal_counters
   import bpred_pkg::*;
(
   input  logic            clock,
   input  logic            reset,
   input  logic [XLEN-1:0] fetch_pc,
   input  resolve_t        resolve [2],
   output logic            predict_taken
);

   ctr_state_e ctr [BHT_SIZE];

   logic [BHT_IDX_LEN-1:0] rd_idx;
   logic [BHT_IDX_LEN-1:0] up_idx [2];
   ctr_state_e             base_1;
   ctr_state_e             upd [2];

   function automatic ctr_state_e sat_next(input ctr_state_e cur, input logic taken);
      ctr_state_e nxt;
      unique case (cur)
         STRONG_NT: nxt = taken ? WEAK_NT  : STRONG_NT;
         WEAK_NT:   nxt = taken ? WEAK_T   : STRONG_NT;
         WEAK_T:    nxt = taken ? STRONG_T : WEAK_NT;
         default:   nxt = taken ? STRONG_T : WEAK_T;
      endcase
      return nxt;
   endfunction

   assign rd_idx        = fetch_pc[BHT_IDX_LEN+1:2];
   assign predict_taken = ctr[rd_idx] inside {WEAK_T, STRONG_T};

   assign up_idx[0] = resolve[0].pc[BHT_IDX_LEN+1:2];
   assign up_idx[1] = resolve[1].pc[BHT_IDX_LEN+1:2];

   // Port 1 builds on port 0's result when both name one counter
   always_comb begin
      upd[0] = sat_next(ctr[up_idx[0]], resolve[0].taken);
      base_1 = (resolve[0].valid && up_idx[1] == up_idx[0]) ? upd[0] : ctr[up_idx[1]];
      upd[1] = sat_next(base_1, resolve[1].taken);
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         for (int i = 0; i < BHT_SIZE; i++) begin
            ctr[i] <= WEAK_NT;
         end
      end else begin
         if (resolve[0].valid) begin
            ctr[up_idx[0]] <= upd[0];
         end
         if (resolve[1].valid) begin
            ctr[up_idx[1]] <= upd[1];
         end
      end
   end

endmodule

/* src/bpred_pkg.sv */
// Branch predictor shared types: address widths, table geometry and bundles
package bpred_pkg;

   //////////////////////////////////////////////////
   // Geometry
   //////////////////////////////////////////////////

   localparam int XLEN        = 32;
   localparam int BTB_IDX_LEN = 4;
   localparam int BTB_SETS    = 1 << BTB_IDX_LEN;
   // Tag and index together cover PC bits 15 down to 2
   localparam int BTB_TAG_LEN = 10;
   localparam int BHT_IDX_LEN = 6;
   localparam int BHT_SIZE    = 1 << BHT_IDX_LEN;

   localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;

   //////////////////////////////////////////////////
   // Types
   //////////////////////////////////////////////////

   typedef enum logic [1:0] {
      STRONG_NT = 2'b00,
      WEAK_NT   = 2'b01,
      WEAK_T    = 2'b10,
      STRONG_T  = 2'b11
   } ctr_state_e;

   // One branch resolved by the back end
   typedef struct packed {
      logic            valid;
      logic [XLEN-1:0] pc;
      logic [XLEN-1:0] target;
      logic            taken;
   } resolve_t;

   // Fetch output towards decode
   typedef struct packed {
      logic            valid;
      logic [XLEN-1:0] pc;
      logic [XLEN-1:0] next_pc;
      logic            taken;
   } predict_t;

   typedef struct packed {
      logic            hit;
      logic [XLEN-1:0] target;
   } btb_lookup_t;

endpackage

/* src/branch_predictor.sv */
// Branch prediction front end: fetch PC generator steered by the BTB and the bimodal table
`timescale 1ns/1ps

module branch_predictor
   import bpred_pkg::*;
(
   input  logic            clock,
   input  logic            reset,
   input  logic            stall,
   input  logic            redirect_valid,
   input  logic [XLEN-1:0] redirect_pc,
   input  resolve_t        resolve [2],
   output predict_t        prediction
);

   logic [XLEN-1:0] fetch_pc;
   btb_lookup_t     lookup;
   logic            predict_taken;

   fetch_pc_gen fetch_pc_gen_i (
      .clock          (clock),
      .reset          (reset),
      .stall          (stall),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc),
      .lookup         (lookup),
      .predict_taken  (predict_taken),
      .fetch_pc       (fetch_pc),
      .prediction     (prediction)
   );

   // Both tables learn from both resolve ports
   btb btb_i (
      .clock    (clock),
      .reset    (reset),
      .fetch_pc (fetch_pc),
      .resolve  (resolve),
      .lookup   (lookup)
   );

   bimodal_counters bimodal_counters_i (
      .clock         (clock),
      .reset         (reset),
      .fetch_pc      (fetch_pc),
      .resolve       (resolve),
      .predict_taken (predict_taken)
   );

endmodule

/* src/btb.sv */
// Two-way set-associative branch target buffer with per-set LRU and two write ports
`timescale 1ns/1ps

module btb
   import bpred_pkg::*;
(
   input  logic        clock,
   input  logic        reset,
   input  logic [XLEN-1:0] fetch_pc,
   input  resolve_t    resolve [2],
   output btb_lookup_t lookup
);

   logic [BTB_SETS-1:0]    valid [2];
   logic [BTB_TAG_LEN-1:0] tags [2][BTB_SETS];
   logic [XLEN-1:0]        targets [2][BTB_SETS];
   // LRU bit names the way to replace next
   logic [BTB_SETS-1:0]    lru;
   logic [BTB_SETS-1:0]    next_lru;

   logic [BTB_TAG_LEN-1:0] rd_tag;
   logic [BTB_IDX_LEN-1:0] rd_idx;
   logic [1:0]             rd_match;

   logic [BTB_TAG_LEN-1:0] wr_tag [2];
   logic [BTB_IDX_LEN-1:0] wr_idx [2];
   logic [1:0]             wr_match [2];
   logic [1:0]             wr_en;
   logic [1:0]             wr_way;

   //////////////////////////////////////////////////
   // Read side
   //////////////////////////////////////////////////

   assign {rd_tag, rd_idx} = fetch_pc[15:2];

   assign rd_match[0] = valid[0][rd_idx] && tags[0][rd_idx] == rd_tag;
   assign rd_match[1] = valid[1][rd_idx] && tags[1][rd_idx] == rd_tag;

   // Way 0 wins when both match
   assign lookup.hit    = |rd_match;
   assign lookup.target = rd_match[0] ? targets[0][rd_idx] : targets[1][rd_idx];

   //////////////////////////////////////////////////
   // Write decode and replacement
   //////////////////////////////////////////////////

   always_comb begin
      for (int p = 0; p < 2; p++) begin
         {wr_tag[p], wr_idx[p]} = resolve[p].pc[15:2];
         for (int w = 0; w < 2; w++) begin
            wr_match[p][w] = valid[w][wr_idx[p]] && tags[w][wr_idx[p]] == wr_tag[p];
         end
      end
      wr_en[0] = resolve[0].valid && resolve[0].taken;
      // Port 1 loses a same-set conflict
      wr_en[1] = resolve[1].valid && resolve[1].taken &&
                 !(wr_en[0] && wr_idx[1] == wr_idx[0]);
   end

   // Read hit first, then port 0, then port 1
   always_comb begin
      next_lru = lru;
      if (rd_match[0]) begin
         next_lru[rd_idx] = 1'b1;
      end else if (rd_match[1]) begin
         next_lru[rd_idx] = 1'b0;
      end
      for (int p = 0; p < 2; p++) begin
         if (wr_match[p][0]) begin
            wr_way[p] = 1'b0;
         end else if (wr_match[p][1]) begin
            wr_way[p] = 1'b1;
         end else begin
            wr_way[p] = next_lru[wr_idx[p]];
         end
         if (wr_en[p]) begin
            next_lru[wr_idx[p]] = ~wr_way[p];
         end
      end
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         valid[0] <= '0;
         valid[1] <= '0;
         lru      <= '0;
      end else begin
         lru <= next_lru;
         for (int p = 0; p < 2; p++) begin
            if (wr_en[p]) begin
               valid[wr_way[p]][wr_idx[p]] <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clock) begin
      for (int p = 0; p < 2; p++) begin
         if (wr_en[p]) begin
            tags[wr_way[p]][wr_idx[p]]    <= wr_tag[p];
            targets[wr_way[p]][wr_idx[p]] <= resolve[p].target;
         end
      end
   end

   // A set never holds one branch twice
   for (genvar s = 0; s < BTB_SETS; s++) begin : g_dup_check
      a_no_dup_tag: assert property (@(posedge clock) disable iff (reset)
         !(valid[0][s] && valid[1][s] && tags[0][s] == tags[1][s]));
   end

endmodule

/* src/fetch_pc_gen.sv */
// Fetch PC register with next-PC selection and the per-cycle prediction
`timescale 1ns/1ps

module fetch_pc_gen
   import bpred_pkg::*;
(
   input  logic            clock,
   input  logic            reset,
   input  logic            stall,
   input  logic            redirect_valid,
   input  logic [XLEN-1:0] redirect_pc,
   input  btb_lookup_t     lookup,
   input  logic            predict_taken,
   output logic [XLEN-1:0] fetch_pc,
   output predict_t        prediction
);

   logic [XLEN-1:0] pc_q;
   logic            valid_q;
   logic            pred_taken;
   logic [XLEN-1:0] next_pc;

   // Redirect, then predicted target, then sequential
   assign pred_taken = lookup.hit && predict_taken;
   assign next_pc    = redirect_valid ? redirect_pc :
                       pred_taken     ? lookup.target : pc_q + 32'd4;

   always_ff @(posedge clock) begin
      if (reset) begin
         pc_q    <= RESET_PC;
         valid_q <= 1'b0;
      end else begin
         valid_q <= 1'b1;
         if (redirect_valid || !stall) begin
            pc_q <= next_pc;
         end
      end
   end

   assign fetch_pc           = pc_q;
   assign prediction.valid   = valid_q;
   assign prediction.pc      = pc_q;
   assign prediction.next_pc = next_pc;
   assign prediction.taken   = pred_taken && !redirect_valid;

   a_pc_aligned: assert property (@(posedge clock) disable iff (reset)
      fetch_pc[1:0] == 2'b00);

endmodule
